// ==== all.f ====
+incdir+common
common/hisPkg.sv
hdl/frameSequencer.sv
histogram/binMapper.sv
histogram/histogramRam.sv
histogram/peakTracker.sv
hdl/windowCalc.sv
hdl/hisBuilderTop.sv
sim/hisBuilderTb.sv

// ==== common/hisBuilder_params.svh ====
`ifndef HISBUILDER_PARAMS_SVH
`define HISBUILDER_PARAMS_SVH

// timestamp width per sample
`define HIS_NP 8

// bin address width, 16 bins per histogram
// and 16 values in the fine window
`define HIS_NB 4

// pixels sharing one histogram memory
`define HIS_PIXELS 4

// samples per pixel per acquisition
`define HIS_SAMPLES 4

// acquisitions per pass
`define HIS_ACQS 2

// bin counter width
`define HIS_COUNT_W 8

`endif

// ==== common/hisPkg.sv ====
`default_nettype none
`include "hisBuilder_params.svh"

package hisPkg;

    // raw timestamp from the sensor
    typedef logic [`HIS_NP-1:0] timestampT;

    // bin address within one pixel histogram
    typedef logic [`HIS_NB-1:0] binT;

    // occupancy of one bin
    typedef logic [`HIS_COUNT_W-1:0] countT;

    // pixel index
    typedef logic [1:0] pixelT;

    // one timestamp per pixel, pixel 0 in the low bits
    typedef logic [`HIS_PIXELS*`HIS_NP-1:0] peakVecT;

    // coarse pass first, then fine pass
    typedef enum logic {
        passCoarse,
        passFine
    } passT;

endpackage

`default_nettype wire

// ==== hdl/frameSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module frameSequencer import hisPkg::*; (
    input  wire logic      clk,
    input  wire logic      res,
    input  wire logic      wrEn,
    input  wire timestampT data,
    output logic           sampleValid,
    output timestampT      sample,
    output pixelT          pixel,
    output passT           pass,
    output logic           passLast
);

    localparam int sampW = (`HIS_SAMPLES > 1) ? $clog2(`HIS_SAMPLES) : 1;
    localparam int acqW  = (`HIS_ACQS > 1) ? $clog2(`HIS_ACQS) : 1;

    logic [sampW-1:0] sampCnt;
    pixelT            pixCnt;
    logic [acqW-1:0]  acqCnt;
    passT             passState;
    logic             lastSample;

    // final sample of the final pixel of the final acquisition
    assign lastSample = wrEn
                     && sampCnt == sampW'(`HIS_SAMPLES - 1)
                     && pixCnt == pixelT'(`HIS_PIXELS - 1)
                     && acqCnt == acqW'(`HIS_ACQS - 1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sampCnt     <= '0;
            pixCnt      <= '0;
            acqCnt      <= '0;
            passState   <= passCoarse;
            pass        <= passCoarse;
            sampleValid <= 1'b0;
            passLast    <= 1'b0;
        end else begin
            sampleValid <= wrEn;
            passLast    <= lastSample;
            if (wrEn) begin
                // pass tag holds until the next accepted sample
                pass <= passState;
                // samples nest inside pixels, pixels inside acquisitions
                if (sampCnt == sampW'(`HIS_SAMPLES - 1)) begin
                    sampCnt <= '0;
                    if (pixCnt == pixelT'(`HIS_PIXELS - 1)) begin
                        pixCnt <= '0;
                        if (acqCnt == acqW'(`HIS_ACQS - 1)) begin
                            acqCnt <= '0;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                    end
                end else begin
                    sampCnt <= sampCnt + 1'b1;
                end
                if (lastSample) begin
                    passState <= (passState == passCoarse) ? passFine : passCoarse;
                end
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (wrEn) begin
            sample <= data;
            pixel  <= pixCnt;
        end
    end

    // downstream clear and window update need the idle gap
    idleAfterPass: assert property (@(posedge clk) disable iff (!res)
        passLast |-> !wrEn [*4])
        else $error("wrEn inside the idle gap after a pass");

endmodule

`default_nettype wire

// ==== hdl/hisBuilderTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module hisBuilderTop import hisPkg::*; (
    input  wire logic      clk,
    input  wire logic      res,
    input  wire logic      wrEn,
    input  wire timestampT data,
    output peakVecT        peakValues,
    output logic           resultValid
);

    // sequencer tags
    logic      sampleValid;
    timestampT sample;
    pixelT     seqPixel;
    passT      seqPass;
    logic      seqPassLast;

    // mapper outputs
    logic      binValid;
    binT       mapBin;
    pixelT     mapPixel;
    logic      mapPassLast;
    passT      mapPass;

    // histogram outputs
    logic      countValid;
    countT     count;
    binT       ramBin;
    pixelT     ramPixel;
    logic      ramPassLast;

    // tracker to window
    logic      passDone;
    passT      donePass;
    logic [`HIS_PIXELS*`HIS_NB-1:0] peakBins;
    peakVecT   lowerBounds;

    frameSequencer sequencer (
        .clk         (clk),
        .res         (res),
        .wrEn        (wrEn),
        .data        (data),
        .sampleValid (sampleValid),
        .sample      (sample),
        .pixel       (seqPixel),
        .pass        (seqPass),
        .passLast    (seqPassLast)
    );

    binMapper mapper (
        .clk         (clk),
        .res         (res),
        .sampleValid (sampleValid),
        .sample      (sample),
        .pixel       (seqPixel),
        .pass        (seqPass),
        .passLast    (seqPassLast),
        .lowerBounds (lowerBounds),
        .binValid    (binValid),
        .bin         (mapBin),
        .pixelOut    (mapPixel),
        .passLastOut (mapPassLast),
        .passOut     (mapPass)
    );

    // pass end strobe clears the bins
    histogramRam ram (
        .clk         (clk),
        .res         (res),
        .binValid    (binValid),
        .bin         (mapBin),
        .pixel       (mapPixel),
        .passLast    (mapPassLast),
        .clear       (passDone),
        .countValid  (countValid),
        .count       (count),
        .binOut      (ramBin),
        .pixelOut    (ramPixel),
        .passLastOut (ramPassLast)
    );

    peakTracker tracker (
        .clk        (clk),
        .res        (res),
        .countValid (countValid),
        .count      (count),
        .bin        (ramBin),
        .pixel      (ramPixel),
        .passLast   (ramPassLast),
        .passIn     (mapPass),
        .passDone   (passDone),
        .donePass   (donePass),
        .peakBins   (peakBins)
    );

    windowCalc window (
        .clk         (clk),
        .res         (res),
        .passDone    (passDone),
        .donePass    (donePass),
        .peakBins    (peakBins),
        .lowerBounds (lowerBounds),
        .peakValues  (peakValues),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== hdl/windowCalc.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module windowCalc import hisPkg::*; (
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  passDone,
    input  wire passT  donePass,
    input  wire logic [`HIS_PIXELS*`HIS_NB-1:0] peakBins,
    output peakVecT    lowerBounds,
    output peakVecT    peakValues,
    output logic       resultValid
);

    localparam int coarseW  = 1 << (`HIS_NP - `HIS_NB);
    localparam int windowW  = 1 << `HIS_NB;
    localparam int topBound = (1 << `HIS_NP) - windowW;

    peakVecT nextBounds;
    peakVecT nextPeaks;

    // window centred on the middle of the coarse peak bin
    always_comb begin
        int lo;
        for (int p = 0; p < `HIS_PIXELS; p++) begin
            lo = int'(peakBins[p*`HIS_NB +: `HIS_NB]) * coarseW
               + coarseW / 2 - windowW / 2;
            // keep the whole window inside the timestamp range
            if (lo < 0) begin
                lo = 0;
            end else if (lo > topBound) begin
                lo = topBound;
            end
            nextBounds[p*`HIS_NP +: `HIS_NP] = timestampT'(lo);
        end
    end

    // fine bin is an offset from the window start
    always_comb begin
        for (int p = 0; p < `HIS_PIXELS; p++) begin
            nextPeaks[p*`HIS_NP +: `HIS_NP] = lowerBounds[p*`HIS_NP +: `HIS_NP]
                + timestampT'(peakBins[p*`HIS_NB +: `HIS_NB]);
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            lowerBounds <= '0;
            peakValues  <= '0;
            resultValid <= 1'b0;
        end else begin
            // one pulse per frame
            resultValid <= passDone && (donePass == passFine);
            if (passDone) begin
                if (donePass == passCoarse) begin
                    lowerBounds <= nextBounds;
                end else begin
                    peakValues <= nextPeaks;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== histogram/binMapper.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module binMapper import hisPkg::*; (
    input  wire logic      clk,
    input  wire logic      res,
    input  wire logic      sampleValid,
    input  wire timestampT sample,
    input  wire pixelT     pixel,
    input  wire passT      pass,
    input  wire logic      passLast,
    input  wire peakVecT   lowerBounds,
    output logic           binValid,
    output binT            bin,
    output pixelT          pixelOut,
    output logic           passLastOut,
    output passT           passOut
);

    timestampT lowerBound;
    timestampT offset;
    binT       coarseBin;
    binT       fineBin;
    logic      inWindow;
    logic      keep;

    always_comb begin
        lowerBound = lowerBounds[pixel*`HIS_NP +: `HIS_NP];
        // coarse bin is the timestamp msbs
        coarseBin  = sample[`HIS_NP-1 -: `HIS_NB];
        offset     = sample - lowerBound;
        // inside when offset fits in the bin field
        inWindow   = (sample >= lowerBound) && ((offset >> `HIS_NB) == '0);
        fineBin    = offset[`HIS_NB-1:0];
        // fine samples outside the window are dropped
        keep       = (pass == passCoarse) || inWindow;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid    <= 1'b0;
            passLastOut <= 1'b0;
            passOut     <= passCoarse;
        end else begin
            binValid    <= sampleValid && keep;
            // pass end still travels on a dropped sample
            passLastOut <= sampleValid && passLast;
            if (sampleValid) begin
                passOut <= pass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            bin      <= (pass == passCoarse) ? coarseBin : fineBin;
            pixelOut <= pixel;
        end
    end

endmodule

`default_nettype wire

// ==== histogram/histogramRam.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module histogramRam import hisPkg::*; (
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  binValid,
    input  wire binT   bin,
    input  wire pixelT pixel,
    input  wire logic  passLast,
    input  wire logic  clear,
    output logic       countValid,
    output countT      count,
    output binT        binOut,
    output pixelT      pixelOut,
    output logic       passLastOut
);

    localparam int depth = `HIS_PIXELS << `HIS_NB;
    localparam int addrW = $clog2(depth);

    countT            mem [depth];
    // a clear bit marks a bin as empty whatever mem holds
    logic [depth-1:0] validBits;
    logic [addrW-1:0] addr;
    countT            nextCount;

    // one histogram per pixel, bins contiguous
    assign addr = {pixel, bin};

    // read and increment in the same stage, so repeats of a bin are safe
    assign nextCount = validBits[addr] ? mem[addr] + countT'(1) : countT'(1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            validBits   <= '0;
            countValid  <= 1'b0;
            passLastOut <= 1'b0;
        end else begin
            countValid  <= binValid;
            passLastOut <= passLast;
            // lazy clear at pass end
            if (clear) begin
                validBits <= '0;
            end else if (binValid) begin
                validBits[addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (binValid) begin
            mem[addr] <= nextCount;
            count     <= nextCount;
            binOut    <= bin;
            pixelOut  <= pixel;
        end
    end

    // a wrapped counter would show up as zero
    noWrap: assert property (@(posedge clk) disable iff (!res)
        binValid |=> count != '0)
        else $error("bin counter wrapped");

endmodule

`default_nettype wire

// ==== histogram/peakTracker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module peakTracker import hisPkg::*; (
    input  wire logic  clk,
    input  wire logic  res,
    input  wire logic  countValid,
    input  wire countT count,
    input  wire binT   bin,
    input  wire pixelT pixel,
    input  wire logic  passLast,
    input  wire passT  passIn,
    output logic       passDone,
    output passT       donePass,
    output logic [`HIS_PIXELS*`HIS_NB-1:0] peakBins
);

    countT maxCount [`HIS_PIXELS];
    binT   maxBin   [`HIS_PIXELS];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            passDone <= 1'b0;
            donePass <= passCoarse;
            for (int p = 0; p < `HIS_PIXELS; p++) begin
                maxCount[p] <= '0;
                maxBin[p]   <= '0;
            end
        end else begin
            passDone <= passLast;
            if (passLast) begin
                donePass <= passIn;
            end
            // windowCalc samples the bins on this same edge
            if (passDone) begin
                for (int p = 0; p < `HIS_PIXELS; p++) begin
                    maxCount[p] <= '0;
                    maxBin[p]   <= '0;
                end
            end else if (countValid && count > maxCount[pixel]) begin
                // strictly greater, earlier bin keeps a tie
                maxCount[pixel] <= count;
                maxBin[pixel]   <= bin;
            end
        end
    end

    // flatten, pixel 0 low
    always_comb begin
        for (int p = 0; p < `HIS_PIXELS; p++) begin
            peakBins[p*`HIS_NB +: `HIS_NB] = maxBin[p];
        end
    end

    // a count on the clearing edge would be lost
    noCountOnClear: assert property (@(posedge clk) disable iff (!res)
        passDone |-> !countValid)
        else $error("count arrived on the pass-end clear");

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module hisBuilderTb -Mdir obj_dir -o simHisBuilder > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simHisBuilder > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/hisBuilderTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "hisBuilder_params.svh"

module hisBuilderTb import hisPkg::*; ();

    localparam int numRows       = 6;
    localparam int resetCycles   = 8;
    localparam int gapCycles     = 8;
    localparam int resultLatency = 4;
    localparam int passSamples   = `HIS_ACQS * `HIS_PIXELS * `HIS_SAMPLES;
    localparam int frameCycles   = 2 * (passSamples + gapCycles);
    // nominal run length in ns, doubled
    localparam longint timeLimit = 2 * longint'(numRows * frameCycles + resetCycles) * 100;

    logic      clk;
    logic      res;
    logic      wrEn;
    timestampT data;
    peakVecT   peakValues;
    logic      resultValid;

    // one byte per pixel, pixel 0 low
    peakVecT targetTab [numRows];
    peakVecT noiseTab  [numRows];
    peakVecT expectTab [numRows];
    string   nameTab   [numRows];

    int errorCount;
    int testsRun;
    int testsFailed;
    int pulseCount;

    hisBuilderTop uut (
        .clk         (clk),
        .res         (res),
        .wrEn        (wrEn),
        .data        (data),
        .peakValues  (peakValues),
        .resultValid (resultValid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // result strobes over the whole run
    always @(negedge clk) begin
        if (res && resultValid) begin
            pulseCount++;
        end
    end

    // pixel order in the literals is 3, 2, 1, 0
    function automatic void loadTable();
        nameTab[0] = "mid-range targets";
        targetTab[0] = {8'd129, 8'd200, 8'd37, 8'd100};
        noiseTab[0]  = {8'd240, 8'd60, 8'd180, 8'd20};
        expectTab[0] = {8'd129, 8'd200, 8'd37, 8'd100};
        nameTab[1] = "clamped windows";
        targetTab[1] = {8'd3, 8'd252, 8'd252, 8'd3};
        noiseTab[1]  = {8'd255, 8'd0, 8'd10, 8'd130};
        expectTab[1] = {8'd3, 8'd252, 8'd252, 8'd3};
        nameTab[2] = "noise in target coarse bin";
        targetTab[2] = {8'd129, 8'd200, 8'd37, 8'd100};
        noiseTab[2]  = {8'd140, 8'd207, 8'd46, 8'd111};
        expectTab[2] = {8'd129, 8'd200, 8'd37, 8'd100};
        nameTab[3] = "back-to-back frame a";
        targetTab[3] = {8'd128, 8'd127, 8'd16, 8'd15};
        noiseTab[3]  = {8'd60, 8'd5, 8'd240, 8'd250};
        expectTab[3] = {8'd128, 8'd127, 8'd16, 8'd15};
        nameTab[4] = "back-to-back frame b";
        targetTab[4] = {8'd191, 8'd64, 8'd0, 8'd255};
        noiseTab[4]  = {8'd103, 8'd102, 8'd101, 8'd100};
        expectTab[4] = {8'd191, 8'd64, 8'd0, 8'd255};
        nameTab[5] = "back-to-back frame c";
        targetTab[5] = {8'd231, 8'd99, 8'd160, 8'd8};
        noiseTab[5]  = {8'd90, 8'd140, 8'd30, 8'd200};
        expectTab[5] = {8'd231, 8'd99, 8'd160, 8'd8};
    endfunction

    task automatic checkValue(input string what, input logic [63:0] got,
                              input logic [63:0] expVal);
        if (got !== expVal) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expVal);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testsRun++;
        if (errorCount == errsBefore) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end
    endtask

    // one pass, three targets and one noise sample per pixel and acquisition
    task automatic sendPass(input int row);
        int        noisePos;
        timestampT target;
        timestampT noise;
        for (int acq = 0; acq < `HIS_ACQS; acq++) begin
            for (int pix = 0; pix < `HIS_PIXELS; pix++) begin
                target   = targetTab[row][pix*`HIS_NP +: `HIS_NP];
                noise    = noiseTab[row][pix*`HIS_NP +: `HIS_NP];
                noisePos = int'($urandom % `HIS_SAMPLES);
                for (int s = 0; s < `HIS_SAMPLES; s++) begin
                    @(posedge clk);
                    wrEn <= 1'b1;
                    data <= (s == noisePos) ? noise : target;
                end
            end
        end
        // DUT takes the last sample on this edge
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic runFrame(input int row);
        int   errsBefore;
        int   latency;
        logic seen;
        errsBefore = errorCount;
        sendPass(row);
        // idle gap lets the window settle
        repeat (gapCycles) @(posedge clk);
        sendPass(row);
        // edges from the last fine sample up to the strobe
        latency = 0;
        seen    = 1'b0;
        while (!seen && latency < 2 * gapCycles) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            seen = resultValid;
        end
        if (!seen) begin
            $display("row %0d: no result strobe within %0d cycles of the last sample",
                     row, latency);
            errorCount++;
        end else begin
            checkValue("result latency", latency, resultLatency);
            checkValue("peakValues", peakValues, expectTab[row]);
        end
        // strobe lasts one cycle
        @(negedge clk);
        checkValue("resultValid after strobe", resultValid, 1'b0);
        reportTest(nameTab[row], errsBefore);
    endtask

    initial begin
        int unsigned seedValue;
        int unsigned discard;
        int          errsBefore;
        seedValue   = 32'h0b91_ca9e;
        discard     = $urandom(seedValue);
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        pulseCount  = 0;
        res         = 1'b0;
        wrEn        = 1'b0;
        data        = '0;
        loadTable();
        repeat (resetCycles) @(posedge clk);
        res <= 1'b1;

        // idle outputs before any frame
        @(negedge clk);
        errsBefore = errorCount;
        checkValue("resultValid after reset", resultValid, 1'b0);
        checkValue("peakValues after reset", peakValues, '0);
        reportTest("reset state", errsBefore);

        for (int row = 0; row < numRows; row++) begin
            runFrame(row);
        end

        errsBefore = errorCount;
        checkValue("result strobe count", pulseCount, numRows);
        reportTest("one strobe per frame", errsBefore);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeLimit);
        $display("timeout: run did not finish within %0d ns", timeLimit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
